/* Bender.yml */
package:
  name: l2c_normal_loop

sources:
  - files:
      - design/nl_pkg.sv
      - design/layer_cfg_decode.sv
      - design/fifo_txn_tracker.sv
      - design/normal_loop_ctrl.sv
      - design/l2c_normal_loop_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_l2c_normal_loop.sv

/* design/fifo_txn_tracker.sv */
// Tracks the outstanding pops or pushes of one FIFO kind.
// Loads mask and counts with the command, counts down on strobes.

`default_nettype none

module fifo_txn_tracker #(
    parameter int unsigned NUM_FIFO = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_i,
    input  nl_pkg::fifo_mask_t  mask_i,
    input  nl_pkg::cnt_t        cnt_i [NUM_FIFO],
    input  logic [NUM_FIFO-1:0] strobe_i,
    output logic [NUM_FIFO-1:0] done_o
);
    import nl_pkg::*;

    logic [NUM_FIFO-1:0] en_q;           // FIFO taking part in this layer
    cnt_t                rem_q [NUM_FIFO]; // transfers still owed

    // ==============================
    // per-FIFO counters
    // ==============================
    for (genvar k = 0; k < NUM_FIFO; k++) begin : g_fifo
        logic hit; // strobe that consumes a count

        assign hit = strobe_i[k] & en_q[k] & (rem_q[k] != '0);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                en_q[k]  <= 1'b0;
                rem_q[k] <= '0;
            end else if (load_i) begin
                en_q[k]  <= mask_i[k]; // strobes in the load cycle are dropped
                rem_q[k] <= cnt_i[k];
            end else if (hit) begin
                rem_q[k] <= rem_q[k] - cnt_t'(1);
            end
        end

        assign done_o[k] = ~en_q[k] | (rem_q[k] == '0);

        // the FIFO side pushed or popped more often than commanded
        over_strobe_a: assert property (@(posedge clk) disable iff (!rst_n)
            (strobe_i[k] && en_q[k] && !load_i) |-> (rem_q[k] != '0));
    end

endmodule

`default_nettype wire

/* design/l2c_normal_loop_top.sv */
// Top of the L2 controller normal-loop stage.
// Decoder, sequencer and one tracker per FIFO kind; NUM_FIFO is set here.

`default_nettype none

module l2c_normal_loop_top #(
    parameter int unsigned NUM_FIFO = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  nl_pkg::layer_cfg_t  cfg_i,        // hold stable until loop_done_o
    input  logic                start_i,
    input  logic [NUM_FIFO-1:0] ifmap_pop_i,
    input  logic [NUM_FIFO-1:0] ipsum_pop_i,
    input  logic [NUM_FIFO-1:0] opsum_push_i,
    output logic                cmd_valid_o,
    output nl_pkg::fifo_mask_t  ifmap_mask_o,
    output nl_pkg::fifo_mask_t  ipsum_mask_o,
    output nl_pkg::fifo_mask_t  opsum_mask_o,
    output nl_pkg::cnt_t        ifmap_cnt_o [NUM_FIFO],
    output nl_pkg::cnt_t        ipsum_cnt_o [NUM_FIFO],
    output nl_pkg::cnt_t        opsum_cnt_o [NUM_FIFO],
    output logic                loop_done_o
);
    logic [NUM_FIFO-1:0] ifmap_done;
    logic [NUM_FIFO-1:0] ipsum_done;
    logic [NUM_FIFO-1:0] opsum_done;

    // ==============================
    // decode and sequencing
    // ==============================
    layer_cfg_decode #(.NUM_FIFO(NUM_FIFO)) u_decode (
        .cfg_i        (cfg_i),
        .ifmap_mask_o (ifmap_mask_o),
        .ipsum_mask_o (ipsum_mask_o),
        .opsum_mask_o (opsum_mask_o),
        .ifmap_cnt_o  (ifmap_cnt_o),
        .ipsum_cnt_o  (ipsum_cnt_o),
        .opsum_cnt_o  (opsum_cnt_o)
    );

    normal_loop_ctrl #(.NUM_FIFO(NUM_FIFO)) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .ifmap_done_i (ifmap_done),
        .ipsum_done_i (ipsum_done),
        .opsum_done_i (opsum_done),
        .cmd_valid_o  (cmd_valid_o),
        .loop_done_o  (loop_done_o)
    );

    // ==============================
    // completion trackers
    // ==============================
    fifo_txn_tracker #(.NUM_FIFO(NUM_FIFO)) u_ifmap_trk (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (cmd_valid_o), // command cycle doubles as load
        .mask_i   (ifmap_mask_o),
        .cnt_i    (ifmap_cnt_o),
        .strobe_i (ifmap_pop_i),
        .done_o   (ifmap_done)
    );

    fifo_txn_tracker #(.NUM_FIFO(NUM_FIFO)) u_ipsum_trk (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (cmd_valid_o),
        .mask_i   (ipsum_mask_o),
        .cnt_i    (ipsum_cnt_o),
        .strobe_i (ipsum_pop_i),
        .done_o   (ipsum_done)
    );

    fifo_txn_tracker #(.NUM_FIFO(NUM_FIFO)) u_opsum_trk (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (cmd_valid_o),
        .mask_i   (opsum_mask_o),
        .cnt_i    (opsum_cnt_o),
        .strobe_i (opsum_push_i),
        .done_o   (opsum_done)
    );

endmodule

`default_nettype wire

/* design/layer_cfg_decode.sv */
// Decode of one layer's shape into the three L3 FIFO commands.
// Purely combinational; outputs are sampled while the sequencer issues the command.

`default_nettype none

module layer_cfg_decode #(
    parameter int unsigned NUM_FIFO = 32
) (
    input  nl_pkg::layer_cfg_t cfg_i,
    output nl_pkg::fifo_mask_t ifmap_mask_o,
    output nl_pkg::fifo_mask_t ipsum_mask_o,
    output nl_pkg::fifo_mask_t opsum_mask_o,
    output nl_pkg::cnt_t       ifmap_cnt_o [NUM_FIFO],
    output nl_pkg::cnt_t       ipsum_cnt_o [NUM_FIFO],
    output nl_pkg::cnt_t       opsum_cnt_o [NUM_FIFO]
);
    import nl_pkg::*;

    cnt_t       w_pad;       // row width including padding
    cnt_t       out_c_w;     // out_c widened to count width
    logic [9:0] ifmap_n;     // ifmap FIFOs requested
    logic [9:0] psum_n;      // ipsum/opsum FIFOs requested
    cnt_t       ipsum_first; // FIFO 0 ipsum count
    cnt_t       ipsum_rest;  // all other ipsum FIFOs
    cnt_t       opsum_each;

    // low n bits set, saturating at NUM_FIFO
    function automatic fifo_mask_t low_mask(input logic [9:0] n);
        fifo_mask_t m;
        m = '0;
        for (int k = 0; k < MAX_FIFO; k++) begin
            if (k < NUM_FIFO && k < n) begin
                m[k] = 1'b1;
            end
        end
        return m;
    endfunction

    assign w_pad   = cnt_t'(cfg_i.in_c) + cnt_t'(cfg_i.pad_r) + cnt_t'(cfg_i.pad_l);
    assign out_c_w = cnt_t'(cfg_i.out_c);

    // ==============================
    // enable masks
    // ==============================
    always_comb begin
        case (cfg_i.layer_type)
            LAYER_DEPTHWISE, LAYER_STANDARD: ifmap_n = 10'(cfg_i.ic_real) * 10'd3; // 3 rows per ch
            default:                         ifmap_n = 10'(cfg_i.ic_real);
        endcase
    end

    assign psum_n       = 10'(cfg_i.oc_real);
    assign ifmap_mask_o = low_mask(ifmap_n);
    assign ipsum_mask_o = low_mask(psum_n);
    assign opsum_mask_o = low_mask(psum_n);

    // ==============================
    // per-FIFO counts
    // ==============================
    always_comb begin
        case (cfg_i.layer_type)
            LAYER_POINTWISE: begin
                ipsum_first = cfg_i.on_real;
                ipsum_rest  = cfg_i.on_real + cnt_t'(1);
                opsum_each  = cfg_i.on_real;
            end
            LAYER_LINEAR: begin
                ipsum_first = cfg_i.on_real - cnt_t'(1); // first row already preloaded
                ipsum_rest  = cfg_i.on_real + cnt_t'(1);
                opsum_each  = cfg_i.on_real;
            end
            default: begin // depthwise and standard
                ipsum_first = out_c_w - cnt_t'(1);
                ipsum_rest  = out_c_w;
                opsum_each  = out_c_w;
            end
        endcase
    end

    always_comb begin
        for (int j = 0; j < NUM_FIFO; j++) begin
            case (cfg_i.layer_type)
                LAYER_POINTWISE: ifmap_cnt_o[j] = cfg_i.tile_n;
                // each group of three FIFOs starts one kernel row later
                LAYER_DEPTHWISE: ifmap_cnt_o[j] = w_pad - cnt_t'(3 * (j / 3 + 1)) + cnt_t'(1);
                LAYER_STANDARD:  ifmap_cnt_o[j] = w_pad - cnt_t'(3);
                default:         ifmap_cnt_o[j] = cfg_i.tile_n - cnt_t'(1); // linear
            endcase
            ipsum_cnt_o[j] = (j == 0) ? ipsum_first : ipsum_rest;
            opsum_cnt_o[j] = opsum_each;
        end
    end

endmodule

`default_nettype wire

/* design/nl_pkg.sv */
// Shared types for the L2 controller normal-loop stage.
// Import into a module body, use scoped names in port lists.

`default_nettype none

package nl_pkg;

    // ==============================
    // size limits
    // ==============================
    localparam int unsigned MAX_FIFO = 32; // widest command mask
    localparam int unsigned CNT_W    = 32; // every pop/push count

    typedef logic [CNT_W-1:0]    cnt_t;       // per-FIFO pop or push count
    typedef logic [MAX_FIFO-1:0] fifo_mask_t; // one enable bit per FIFO

    // ==============================
    // layer description
    // ==============================
    typedef enum logic [1:0] {
        LAYER_POINTWISE = 2'd0,
        LAYER_DEPTHWISE = 2'd1,
        LAYER_STANDARD  = 2'd2,
        LAYER_LINEAR    = 2'd3
    } layer_type_e;

    typedef struct packed {
        layer_type_e layer_type;
        logic [7:0]  ic_real;  // active input channels
        logic [7:0]  oc_real;  // active output channels
        logic [31:0] tile_n;   // tiles in this pass
        logic [31:0] on_real;  // output rows to produce
        logic [7:0]  in_c;     // input row width
        logic [1:0]  pad_r;    // right padding
        logic [1:0]  pad_l;    // left padding
        logic [7:0]  out_c;    // output row width
    } layer_cfg_t;

endpackage

`default_nettype wire

/* design/normal_loop_ctrl.sv */
// Normal-loop sequencer: issues the FIFO command once per start
// and waits until every tracker reports its FIFOs done.

`default_nettype none

module normal_loop_ctrl #(
    parameter int unsigned NUM_FIFO = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  logic [NUM_FIFO-1:0] ifmap_done_i,
    input  logic [NUM_FIFO-1:0] ipsum_done_i,
    input  logic [NUM_FIFO-1:0] opsum_done_i,
    output logic                cmd_valid_o,
    output logic                loop_done_o
);
    typedef enum logic [1:0] {
        IDLE,
        SET_NUM,
        WAIT_DONE,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   all_done;

    assign all_done = (&ifmap_done_i) & (&ipsum_done_i) & (&opsum_done_i);

    // ==============================
    // state register and next state
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (start_i) state_d = SET_NUM;    // start ignored elsewhere
            SET_NUM:   state_d = WAIT_DONE;               // trackers load here
            WAIT_DONE: if (all_done) state_d = DONE;
            DONE:      state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    assign cmd_valid_o = (state_q == SET_NUM);
    assign loop_done_o = (state_q == DONE);

    cmd_valid_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid_o |=> !cmd_valid_o);
    loop_done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        loop_done_o |=> !loop_done_o);
    cmd_done_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd_valid_o && loop_done_o));

endmodule

`default_nettype wire

/* l2c_normal_loop_top.f */
design/nl_pkg.sv
design/layer_cfg_decode.sv
design/fifo_txn_tracker.sv
design/normal_loop_ctrl.sv
design/l2c_normal_loop_top.sv
test/tb_clk_gen.sv
test/tb_l2c_normal_loop.sv

/* test/tb_clk_gen.sv */
// Clock and reset for the normal-loop testbench.
// rst_n is held low for the first RST_CYCLES rising edges.

`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on an edge like the other inputs
    end
endmodule

`default_nettype wire

/* test/tb_l2c_normal_loop.sv */
// Testbench for the normal-loop stage: random layers and FIFO strobes,
// checked against a model of the decode rules and the completion timing.

`default_nettype none

module tb_l2c_normal_loop;
    import nl_pkg::*;

    localparam int NUM_FIFO   = 32;
    localparam int NUM_LAYERS = 40;
    localparam int MAX_CYCLES = 8000; // 40 layers x (16 x 4 + 20), with margin

    logic                clk;
    logic                rst_n;
    layer_cfg_t          cfg_i;
    logic                start_i;
    logic [NUM_FIFO-1:0] ifmap_pop_i;
    logic [NUM_FIFO-1:0] ipsum_pop_i;
    logic [NUM_FIFO-1:0] opsum_push_i;
    logic                cmd_valid_o;
    logic                loop_done_o;
    fifo_mask_t          ifmap_mask_o;
    fifo_mask_t          ipsum_mask_o;
    fifo_mask_t          opsum_mask_o;
    cnt_t                ifmap_cnt_o [NUM_FIFO];
    cnt_t                ipsum_cnt_o [NUM_FIFO];
    cnt_t                opsum_cnt_o [NUM_FIFO];

    integer     seed;
    int         errors = 0;
    int         cycles = 0;
    int         layer_idx = -1;
    layer_cfg_t cur_cfg;
    fifo_mask_t exp_mask [3];          // 0 ifmap, 1 ipsum, 2 opsum
    fifo_mask_t prev_mask [3];         // enables still held by the trackers
    cnt_t       exp_cnt [3][NUM_FIFO];
    cnt_t       rem [3][NUM_FIFO];     // model of outstanding transfers

    tb_clk_gen #(.PERIOD(8), .RST_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    l2c_normal_loop_top #(.NUM_FIFO(NUM_FIFO)) DUT (.*);

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_mask(input string name, input fifo_mask_t got, input fifo_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s = %h, expected %h (layer %0d)", name, got, exp, layer_idx);
        end
    endtask

    task automatic check_cnt(input string name, input int idx, input cnt_t got, input cnt_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s[%0d] = %h, expected %h (layer %0d)",
                     name, idx, got, exp, layer_idx);
        end
    endtask

    task automatic check_pulse(input string name, input logic got, input logic exp,
                               input string when);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s = %h, expected %h %s (layer %0d)",
                     name, got, exp, when, layer_idx);
        end
    endtask

    // ==============================
    // reference model
    // ==============================
    task automatic make_layer(input int idx);
        int n;
        int min_w;
        int pads;
        cur_cfg = '0;
        cur_cfg.layer_type = layer_type_e'({$random(seed)} % 4);
        if (idx % 8 != 5) begin // every eighth layer enables no FIFO
            cur_cfg.ic_real = 8'({$random(seed)} % 13);
            cur_cfg.oc_real = 8'({$random(seed)} % 13);
        end
        cur_cfg.tile_n  = 1 + {$random(seed)} % 16;
        cur_cfg.on_real = 1 + {$random(seed)} % 16;
        cur_cfg.out_c   = 8'(1 + {$random(seed)} % 16);
        cur_cfg.pad_r   = 2'({$random(seed)} % 3);
        cur_cfg.pad_l   = 2'({$random(seed)} % 3);
        min_w = 3;
        if (cur_cfg.layer_type == LAYER_DEPTHWISE && cur_cfg.ic_real != 0) begin
            n = (3 * cur_cfg.ic_real > NUM_FIFO) ? NUM_FIFO : 3 * cur_cfg.ic_real;
            min_w = 3 * ((n - 1) / 3) + 2; // last enabled group keeps a count >= 0
        end
        pads = cur_cfg.pad_r + cur_cfg.pad_l;
        cur_cfg.in_c = 8'(((min_w > pads) ? min_w - pads : 0) + {$random(seed)} % 4);
    endtask

    task automatic build_model();
        int  w;
        int  n_if;
        bit  rows3;
        w     = int'(cur_cfg.in_c) + int'(cur_cfg.pad_r) + int'(cur_cfg.pad_l);
        rows3 = (cur_cfg.layer_type == LAYER_DEPTHWISE) || (cur_cfg.layer_type == LAYER_STANDARD);
        n_if  = rows3 ? 3 * int'(cur_cfg.ic_real) : int'(cur_cfg.ic_real);
        for (int k = 0; k < 3; k++) begin
            exp_mask[k] = '0;
        end
        for (int j = 0; j < NUM_FIFO; j++) begin
            exp_mask[0][j] = (j < n_if);
            exp_mask[1][j] = (j < int'(cur_cfg.oc_real));
            exp_mask[2][j] = exp_mask[1][j];
            case (cur_cfg.layer_type)
                LAYER_POINTWISE: exp_cnt[0][j] = cur_cfg.tile_n;
                LAYER_DEPTHWISE: exp_cnt[0][j] = cnt_t'(w - 3 * (j / 3 + 1) + 1);
                LAYER_STANDARD:  exp_cnt[0][j] = cnt_t'(w - 3);
                default:         exp_cnt[0][j] = cur_cfg.tile_n - 1;
            endcase
            if (rows3) begin
                exp_cnt[1][j] = cnt_t'(cur_cfg.out_c) - cnt_t'(j == 0);
                exp_cnt[2][j] = cnt_t'(cur_cfg.out_c);
            end else if (j == 0) begin
                exp_cnt[1][j] = cur_cfg.on_real - cnt_t'(cur_cfg.layer_type == LAYER_LINEAR);
                exp_cnt[2][j] = cur_cfg.on_real;
            end else begin
                exp_cnt[1][j] = cur_cfg.on_real + 1;
                exp_cnt[2][j] = cur_cfg.on_real;
            end
            for (int k = 0; k < 3; k++) begin
                rem[k][j] = exp_cnt[k][j];
            end
        end
    endtask

    function automatic fifo_mask_t pending(input int k);
        fifo_mask_t p;
        p = '0;
        for (int j = 0; j < NUM_FIFO; j++) begin
            p[j] = exp_mask[k][j] && (rem[k][j] != '0);
        end
        return p;
    endfunction

    // ==============================
    // stimulus
    // ==============================
    task automatic strobe_cycle(input bit consume);
        fifo_mask_t sel;
        for (int k = 0; k < 3; k++) begin
            sel = consume ? (fifo_mask_t'($random(seed)) & pending(k)) : '0;
            for (int j = 0; j < NUM_FIFO; j++) begin
                if (sel[j]) begin
                    rem[k][j] = rem[k][j] - 1;
                end
            end
            if ({$random(seed)} % 4 == 0) begin // stray strobes, never on an enabled FIFO
                sel = sel | (fifo_mask_t'($random(seed)) & ~exp_mask[k] & ~prev_mask[k]);
            end
            case (k)
                0:       ifmap_pop_i  <= sel;
                1:       ipsum_pop_i  <= sel;
                default: opsum_push_i <= sel;
            endcase
        end
    endtask

    // one clock: drive on the rising edge, check on the falling edge
    task automatic step(input bit go, input bit consume, input logic exp_cmd,
                        input logic exp_done, input string when);
        @(posedge clk);
        cfg_i   <= cur_cfg;
        start_i <= go;
        strobe_cycle(consume);
        @(negedge clk);
        check_pulse("cmd_valid_o", cmd_valid_o, exp_cmd, when);
        check_pulse("loop_done_o", loop_done_o, exp_done, when);
    endtask

    task automatic run_layer();
        step(1'b0, 1'b0, 1'b0, 1'b0, "before start");
        step(1'b1, 1'b0, 1'b0, 1'b0, "in the start cycle");
        step(1'b0, 1'b0, 1'b1, 1'b0, "in the command cycle");
        check_mask("ifmap_mask_o", ifmap_mask_o, exp_mask[0]);
        check_mask("ipsum_mask_o", ipsum_mask_o, exp_mask[1]);
        check_mask("opsum_mask_o", opsum_mask_o, exp_mask[2]);
        for (int j = 0; j < NUM_FIFO; j++) begin
            if (exp_mask[0][j]) check_cnt("ifmap_cnt_o", j, ifmap_cnt_o[j], exp_cnt[0][j]);
            if (exp_mask[1][j]) check_cnt("ipsum_cnt_o", j, ipsum_cnt_o[j], exp_cnt[1][j]);
            if (exp_mask[2][j]) check_cnt("opsum_cnt_o", j, opsum_cnt_o[j], exp_cnt[2][j]);
        end
        while ((pending(0) | pending(1) | pending(2)) != '0) begin
            step(1'b0, 1'b1, 1'b0, 1'b0, "while counts are pending");
        end
        // the command cycle stands in for the last strobe when nothing is enabled
        step(1'b0, 1'b0, 1'b0, 1'b0, "one cycle after the last strobe");
        step(1'b0, 1'b0, 1'b0, 1'b1, "two cycles after the last strobe");
        for (int k = 0; k < 3; k++) begin
            prev_mask[k] = exp_mask[k];
        end
        step(1'b0, 1'b0, 1'b0, 1'b0, "after the done pulse");
    endtask

    initial begin
        seed         = 32'h80b2;
        cfg_i        = '0;
        start_i      = 1'b0;
        ifmap_pop_i  = '0;
        ipsum_pop_i  = '0;
        opsum_push_i = '0;
        cur_cfg      = '0;
        for (int k = 0; k < 3; k++) begin
            exp_mask[k]  = '0;
            prev_mask[k] = '0;
        end
        wait (rst_n === 1'b1);
        repeat (3) step(1'b0, 1'b0, 1'b0, 1'b0, "after reset");
        for (int i = 0; i < NUM_LAYERS; i++) begin
            layer_idx = i;
            make_layer(i);
            build_model();
            run_layer();
        end
        $display("layers run: %0d, errors: %0d", NUM_LAYERS, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // ==============================
    // run limit
    // ==============================
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run stopped after %0d cycles in layer %0d, loop_done_o never came",
                     MAX_CYCLES, layer_idx);
            $display("layers run: %0d, errors: %0d", layer_idx, errors + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
